//--- llc_cfg_consts.svh
// cache configuration constants
`ifndef LLC_CFG_CONSTS_SVH
`define LLC_CFG_CONSTS_SVH

//////////////////////////////
// cache geometry
//////////////////////////////
`define LLC_NUM_WAYS        8
`define LLC_INDEX_W         4
`define LLC_BLOCK_OFFSET_W  5

//////////////////////////////
// bus widths
//////////////////////////////
`define LLC_ADDR_W          32
`define LLC_LITE_ADDR_W     32
`define LLC_LITE_DATA_W     32

//////////////////////////////
// register map
//////////////////////////////
`define LLC_CFG_BASE        32'h0000_1000
`define LLC_REG_SPM_CFG     32'h0000_0000
`define LLC_REG_FLUSH       32'h0000_0004
`define LLC_REG_FLUSHED     32'h0000_0008
`define LLC_REG_SET_ASSO    32'h0000_000C
`define LLC_REG_NO_LINES    32'h0000_0010

// lite responses
`define LLC_RESP_OKAY       2'd0
`define LLC_RESP_SLVERR     2'd2
`define LLC_BAD_DATA        32'hBADC_0DED

`endif

//--- llc_cfg_pkg.sv
// cache configuration types
`include "llc_cfg_consts.svh"

package llc_cfg_pkg;

  // one bit per cache way
  typedef logic [`LLC_NUM_WAYS-1:0] way_vec_t;

  // everything driven by the lite master
  typedef struct packed {
    logic                          aw_valid;
    logic [`LLC_LITE_ADDR_W-1:0]   aw_addr;
    logic                          w_valid;
    logic [`LLC_LITE_DATA_W-1:0]   w_data;
    logic [`LLC_LITE_DATA_W/8-1:0] w_strb;
    logic                          b_ready;
    logic                          ar_valid;
    logic [`LLC_LITE_ADDR_W-1:0]   ar_addr;
    logic                          r_ready;
  } lite_req_t;

  // everything driven back by the register block
  typedef struct packed {
    logic                        aw_ready;
    logic                        w_ready;
    logic                        b_valid;
    logic [1:0]                  b_resp;
    logic                        ar_ready;
    logic                        r_valid;
    logic [`LLC_LITE_DATA_W-1:0] r_data;
    logic [1:0]                  r_resp;
  } lite_resp_t;

  // end address is exclusive
  typedef struct packed {
    logic [`LLC_ADDR_W-1:0] start_addr;
    logic [`LLC_ADDR_W-1:0] end_addr;
  } addr_rule_t;

  typedef struct packed {
    logic [`LLC_ADDR_W-1:0] addr;
    way_vec_t               way_ind;
    logic                   flush;
  } flush_desc_t;

  typedef struct packed {
    logic isolated;
    logic aw_unit_busy;
    logic ar_unit_busy;
    logic flush_done;
  } cache_stat_t;

  typedef enum logic [2:0] {
    flush_idle,
    flush_wait_isolated,
    flush_wait_units,
    flush_init,
    flush_send,
    flush_wait_done,
    flush_finish
  } flush_state_e;

endpackage

//--- llc_bypass_dec.sv
// main port bypass decode
`timescale 1ns/10ps
`include "llc_cfg_consts.svh"

module llc_bypass_dec import llc_cfg_pkg::*; (
  input  logic [`LLC_ADDR_W-1:0] aw_addr_i,
  input  logic [`LLC_ADDR_W-1:0] ar_addr_i,
  input  addr_rule_t             ram_rule_i,
  input  addr_rule_t             spm_rule_i,
  input  way_vec_t               flushed_i,
  output logic                   aw_bypass_o,
  output logic                   ar_bypass_o
);

  logic all_flushed;

  function automatic logic in_rule(logic [`LLC_ADDR_W-1:0] addr, addr_rule_t rule);
    return (addr >= rule.start_addr) && (addr < rule.end_addr);
  endfunction

  // spm region always stays in the cache
  function automatic logic dec_bypass(logic [`LLC_ADDR_W-1:0] addr, addr_rule_t ram,
                                      addr_rule_t spm, logic flushed);
    if (in_rule(addr, spm)) begin
      return 1'b0;
    end else if (in_rule(addr, ram)) begin
      return flushed;
    end
    return 1'b0;
  endfunction

  // ram goes around the cache only once no way holds data
  assign all_flushed = &flushed_i;

  assign aw_bypass_o = dec_bypass(aw_addr_i, ram_rule_i, spm_rule_i, all_flushed);
  assign ar_bypass_o = dec_bypass(ar_addr_i, ram_rule_i, spm_rule_i, all_flushed);

endmodule

//--- llc_cfg_regs.sv
// configuration register port
`timescale 1ns/10ps
`include "llc_cfg_consts.svh"

module llc_cfg_regs import llc_cfg_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  lite_req_t  lite_req_i,
  output lite_resp_t lite_resp_o,
  input  logic       aw_lock_i,
  input  logic       flush_clear_i,
  input  way_vec_t   flushed_i,
  output way_vec_t   spm_cfg_o,
  output way_vec_t   user_flush_o,
  output logic       flush_req_o
);

  localparam int unsigned StrbW = `LLC_LITE_DATA_W / 8;

  typedef logic [`LLC_LITE_ADDR_W-1:0] lite_addr_t;
  typedef logic [`LLC_LITE_DATA_W-1:0] lite_data_t;

  logic       init_q;
  logic       aw_busy_q, b_busy_q, ar_busy_q;
  lite_addr_t aw_addr_q, ar_addr_q;
  lite_addr_t wr_off, rd_off;
  lite_data_t spm_q, flush_q;
  lite_data_t rdata;
  logic       aw_hs, w_hs, b_hs, ar_hs, r_hs;
  logic       wr_spm, wr_flush;

  // offset relative to the config base
  function automatic logic is_mapped(lite_addr_t off);
    return (off == `LLC_REG_SPM_CFG) || (off == `LLC_REG_FLUSH) ||
           (off == `LLC_REG_FLUSHED) || (off == `LLC_REG_SET_ASSO) ||
           (off == `LLC_REG_NO_LINES);
  endfunction

  //////////////////////////////
  // handshakes
  //////////////////////////////
  assign aw_hs = lite_req_i.aw_valid & lite_resp_o.aw_ready;
  assign w_hs  = lite_req_i.w_valid  & lite_resp_o.w_ready;
  assign b_hs  = lite_req_i.b_ready  & lite_resp_o.b_valid;
  assign ar_hs = lite_req_i.ar_valid & lite_resp_o.ar_ready;
  assign r_hs  = lite_req_i.r_ready  & lite_resp_o.r_valid;

  // init_q holds readies low for the first cycle out of reset
  assign lite_resp_o.aw_ready = init_q & ~aw_busy_q & ~aw_lock_i;
  assign lite_resp_o.w_ready  = aw_busy_q & ~b_busy_q;
  assign lite_resp_o.b_valid  = aw_busy_q & b_busy_q;
  assign lite_resp_o.b_resp   = is_mapped(wr_off) ? `LLC_RESP_OKAY : `LLC_RESP_SLVERR;
  assign lite_resp_o.ar_ready = init_q & ~ar_busy_q;
  assign lite_resp_o.r_valid  = ar_busy_q;
  assign lite_resp_o.r_data   = rdata;
  assign lite_resp_o.r_resp   = is_mapped(rd_off) ? `LLC_RESP_OKAY : `LLC_RESP_SLVERR;

  // a finished write kicks the flush machine
  assign flush_req_o = b_hs;

  //////////////////////////////
  // decode
  //////////////////////////////
  assign wr_off   = aw_addr_q - lite_addr_t'(`LLC_CFG_BASE);
  assign rd_off   = ar_addr_q - lite_addr_t'(`LLC_CFG_BASE);
  assign wr_spm   = w_hs && (wr_off == `LLC_REG_SPM_CFG);
  assign wr_flush = w_hs && (wr_off == `LLC_REG_FLUSH);

  always_comb begin
    case (rd_off)
      `LLC_REG_SPM_CFG:  rdata = spm_q;
      `LLC_REG_FLUSH:    rdata = flush_q;
      `LLC_REG_FLUSHED:  rdata = lite_data_t'(flushed_i);
      `LLC_REG_SET_ASSO: rdata = lite_data_t'(`LLC_NUM_WAYS);
      `LLC_REG_NO_LINES: rdata = lite_data_t'(1 << `LLC_INDEX_W);
      default:           rdata = `LLC_BAD_DATA;
    endcase
  end

  assign spm_cfg_o    = spm_q[`LLC_NUM_WAYS-1:0];
  assign user_flush_o = flush_q[`LLC_NUM_WAYS-1:0];

  //////////////////////////////
  // state and registers
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_q    <= 1'b0;
      aw_busy_q <= 1'b0;
      b_busy_q  <= 1'b0;
      ar_busy_q <= 1'b0;
      spm_q     <= '0;
      flush_q   <= '0;
    end else begin
      init_q <= 1'b1;
      if (aw_hs) begin
        aw_busy_q <= 1'b1;
      end
      if (w_hs) begin
        b_busy_q <= 1'b1;
      end
      if (b_hs) begin
        aw_busy_q <= 1'b0;
        b_busy_q  <= 1'b0;
      end
      if (ar_hs) begin
        ar_busy_q <= 1'b1;
      end else if (r_hs) begin
        ar_busy_q <= 1'b0;
      end
      // byte lanes under strobe
      for (int unsigned i = 0; i < StrbW; i++) begin
        if (wr_spm && lite_req_i.w_strb[i]) begin
          spm_q[8*i +: 8] <= lite_req_i.w_data[8*i +: 8];
        end
        if (wr_flush && lite_req_i.w_strb[i]) begin
          flush_q[8*i +: 8] <= lite_req_i.w_data[8*i +: 8];
        end
      end
      if (flush_clear_i) begin
        flush_q <= '0;
      end
    end
  end

  // captured addresses
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_addr_q <= lite_req_i.aw_addr;
    end
    if (ar_hs) begin
      ar_addr_q <= lite_req_i.ar_addr;
    end
  end

  // write response only ever follows its data beat
  a_b_after_w : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(lite_resp_o.b_valid) |-> $past(w_hs));

endmodule

//--- llc_flush_ctrl.sv
// way flush sequencer
`timescale 1ns/10ps
`include "llc_cfg_consts.svh"

module llc_flush_ctrl import llc_cfg_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_req_i,
  input  way_vec_t    spm_cfg_i,
  input  way_vec_t    user_flush_i,
  input  cache_stat_t cache_stat_i,
  input  logic        desc_ready_i,
  output flush_desc_t desc_o,
  output logic        desc_valid_o,
  output logic        isolate_o,
  output logic        aw_lock_o,
  output logic        flush_clear_o,
  output way_vec_t    flushed_o
);

  localparam int unsigned NumIdx = 1 << `LLC_INDEX_W;

  // one extra bit so a full way of completions fits
  typedef logic [`LLC_INDEX_W:0] done_cnt_t;

  flush_state_e            state_d, state_q;
  way_vec_t                to_flush_d, to_flush_q;
  way_vec_t                flushed_d, flushed_q;
  way_vec_t                cur_way;
  logic [`LLC_INDEX_W-1:0] idx_q;
  done_cnt_t               done_cnt_q;
  logic                    cnt_clr;
  logic                    desc_hs;

  // lowest pending way, one-hot
  assign cur_way = to_flush_q & (~to_flush_q + way_vec_t'(1));
  assign desc_hs = desc_valid_o & desc_ready_i;

  //////////////////////////////
  // fsm
  //////////////////////////////
  always_comb begin
    state_d       = state_q;
    to_flush_d    = to_flush_q;
    flushed_d     = flushed_q;
    flush_clear_o = 1'b0;
    cnt_clr       = 1'b0;
    case (state_q)
      flush_idle: begin
        if (flush_req_i) begin
          state_d = flush_wait_isolated;
        end
      end
      flush_wait_isolated: begin
        if (cache_stat_i.isolated) begin
          state_d = flush_wait_units;
        end
      end
      flush_wait_units: begin
        if (!cache_stat_i.aw_unit_busy && !cache_stat_i.ar_unit_busy) begin
          state_d = flush_init;
        end
      end
      flush_init: begin
        // user request wins over the spm setting
        if (|user_flush_i) begin
          to_flush_d = user_flush_i & ~flushed_q;
        end else begin
          to_flush_d = spm_cfg_i & ~flushed_q;
          flushed_d  = spm_cfg_i & flushed_q;
        end
        if (to_flush_d == '0) begin
          state_d       = flush_idle;
          flush_clear_o = 1'b1;
        end else begin
          state_d = flush_send;
          cnt_clr = 1'b1;
        end
      end
      flush_send: begin
        if (desc_hs && (idx_q == '1)) begin
          state_d = flush_wait_done;
        end
      end
      flush_wait_done: begin
        if (done_cnt_q == done_cnt_t'(NumIdx)) begin
          state_d = flush_finish;
        end
      end
      flush_finish: begin
        if (to_flush_q == cur_way) begin
          // last way done, hand the ways back to the spm setting
          state_d       = flush_idle;
          flushed_d     = spm_cfg_i;
          flush_clear_o = 1'b1;
        end else begin
          state_d   = flush_init;
          flushed_d = flushed_q | cur_way;
        end
      end
      default: begin
        state_d = flush_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= flush_idle;
      to_flush_q <= '0;
      flushed_q  <= '0;
      idx_q      <= '0;
      done_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      to_flush_q <= to_flush_d;
      flushed_q  <= flushed_d;
      if (cnt_clr) begin
        idx_q      <= '0;
        done_cnt_q <= '0;
      end else begin
        if (desc_hs) begin
          idx_q <= idx_q + 1'b1;
        end
        if (cache_stat_i.flush_done) begin
          done_cnt_q <= done_cnt_q + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////
  assign desc_valid_o = (state_q == flush_send);
  assign isolate_o    = (state_q != flush_idle);
  assign aw_lock_o    = (state_q != flush_idle);
  assign flushed_o    = flushed_q;

  always_comb begin
    desc_o         = '0;
    desc_o.addr[`LLC_BLOCK_OFFSET_W +: `LLC_INDEX_W] = idx_q;
    desc_o.way_ind = cur_way;
    desc_o.flush   = 1'b1;
  end

  a_desc_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    desc_valid_o && !desc_ready_i |=> desc_valid_o && $stable(desc_o));

  a_way_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    desc_valid_o |-> $onehot(desc_o.way_ind));

endmodule

//--- llc_cfg_top.sv
// cache configuration block top
`timescale 1ns/10ps
`include "llc_cfg_consts.svh"

module llc_cfg_top import llc_cfg_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // lite config port
  input  lite_req_t              lite_req_i,
  output lite_resp_t             lite_resp_o,
  // cache side
  input  cache_stat_t            cache_stat_i,
  output flush_desc_t            desc_o,
  output logic                   desc_valid_o,
  input  logic                   desc_ready_i,
  output logic                   isolate_o,
  output way_vec_t               spm_lock_o,
  output way_vec_t               flushed_o,
  // main port bypass
  input  logic [`LLC_ADDR_W-1:0] aw_addr_i,
  input  logic [`LLC_ADDR_W-1:0] ar_addr_i,
  input  addr_rule_t             ram_rule_i,
  input  addr_rule_t             spm_rule_i,
  output logic                   aw_bypass_o,
  output logic                   ar_bypass_o
);

  logic     aw_lock;
  logic     flush_clear;
  logic     flush_req;
  way_vec_t user_flush;

  llc_cfg_regs i_regs (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .lite_req_i    ( lite_req_i  ),
    .lite_resp_o   ( lite_resp_o ),
    .aw_lock_i     ( aw_lock     ),
    .flush_clear_i ( flush_clear ),
    .flushed_i     ( flushed_o   ),
    .spm_cfg_o     ( spm_lock_o  ),
    .user_flush_o  ( user_flush  ),
    .flush_req_o   ( flush_req   )
  );

  llc_flush_ctrl i_flush_ctrl (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .flush_req_i   ( flush_req    ),
    .spm_cfg_i     ( spm_lock_o   ),
    .user_flush_i  ( user_flush   ),
    .cache_stat_i  ( cache_stat_i ),
    .desc_ready_i  ( desc_ready_i ),
    .desc_o        ( desc_o       ),
    .desc_valid_o  ( desc_valid_o ),
    .isolate_o     ( isolate_o    ),
    .aw_lock_o     ( aw_lock      ),
    .flush_clear_o ( flush_clear  ),
    .flushed_o     ( flushed_o    )
  );

  llc_bypass_dec i_bypass_dec (
    .aw_addr_i   ( aw_addr_i   ),
    .ar_addr_i   ( ar_addr_i   ),
    .ram_rule_i  ( ram_rule_i  ),
    .spm_rule_i  ( spm_rule_i  ),
    .flushed_i   ( flushed_o   ),
    .aw_bypass_o ( aw_bypass_o ),
    .ar_bypass_o ( ar_bypass_o )
  );

endmodule

//--- tb_llc_cfg.sv
// llc configuration testbench
`timescale 1ns/10ps
`include "llc_cfg_consts.svh"

module tb_llc_cfg import llc_cfg_pkg::*; ();

  localparam int unsigned NumIdx  = 1 << `LLC_INDEX_W;
  // nine ways flushed in total, each up to about 16 x 5 cycles, plus register traffic
  localparam int unsigned Timeout = 4000;
  localparam logic [31:0] Base    = `LLC_CFG_BASE;
  localparam logic [31:0] RamAddr = 32'h8000_1000;
  // spm window sits inside the ram region
  localparam logic [31:0] SpmAddr = 32'h8800_0100;

  logic                   clk_i;
  logic                   rst_ni;
  lite_req_t              req;
  lite_resp_t             rsp;
  cache_stat_t            cache_stat;
  flush_desc_t            desc;
  logic                   desc_valid;
  logic                   desc_ready;
  logic                   isolate;
  way_vec_t               spm_lock;
  way_vec_t               flushed;
  logic [`LLC_ADDR_W-1:0] aw_addr;
  logic [`LLC_ADDR_W-1:0] ar_addr;
  addr_rule_t             ram_rule;
  addr_rule_t             spm_rule;
  logic                   aw_bypass;
  logic                   ar_bypass;

  logic [31:0] lfsr_q;
  int unsigned cycles;
  int unsigned errors;
  int unsigned checks;
  int          ncyc;
  int          last_due;
  int          due_cyc;
  int          dly;
  int          due_q[$];
  flush_desc_t desc_log[$];

  llc_cfg_top dut (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .lite_req_i   ( req        ),
    .lite_resp_o  ( rsp        ),
    .cache_stat_i ( cache_stat ),
    .desc_o       ( desc       ),
    .desc_valid_o ( desc_valid ),
    .desc_ready_i ( desc_ready ),
    .isolate_o    ( isolate    ),
    .spm_lock_o   ( spm_lock   ),
    .flushed_o    ( flushed    ),
    .aw_addr_i    ( aw_addr    ),
    .ar_addr_i    ( ar_addr    ),
    .ram_rule_i   ( ram_rule   ),
    .spm_rule_i   ( spm_rule   ),
    .aw_bypass_o  ( aw_bypass  ),
    .ar_bypass_o  ( ar_bypass  )
  );

  always #5 clk_i = ~clk_i;

  // galois lfsr, one step per bit
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return b;
  endfunction

  //////////////////////////////
  // cache side responder
  //////////////////////////////
  always @(negedge clk_i) begin
    ncyc++;
    cache_stat.isolated   = isolate;
    cache_stat.flush_done = 1'b0;
    if (due_q.size() > 0 && due_q[0] <= ncyc) begin
      void'(due_q.pop_front());
      cache_stat.flush_done = 1'b1;
    end
    desc_ready = lfsr_bit();
    // valid and ready both hold until the next rising edge
    if (desc_valid && desc_ready) begin
      desc_log.push_back(desc);
      dly = lfsr_bit() ? 2 : 0;
      if (lfsr_bit()) begin
        dly = dly + 1;
      end
      due_cyc = ncyc + 1 + dly;
      if (due_cyc <= last_due) begin
        due_cyc = last_due + 1;
      end
      due_q.push_back(due_cyc);
      last_due = due_cyc;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= Timeout) begin
      $display("timeout: the run did not finish within %0d cycles", Timeout);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic lite_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    @(negedge clk_i);
    req.aw_valid = 1'b1;
    req.aw_addr  = addr;
    while (!rsp.aw_ready) @(negedge clk_i);
    @(negedge clk_i);
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b1;
    req.w_data   = data;
    req.w_strb   = strb;
    while (!rsp.w_ready) @(negedge clk_i);
    @(negedge clk_i);
    req.w_valid = 1'b0;
    req.b_ready = 1'b1;
    while (!rsp.b_valid) @(negedge clk_i);
    resp = rsp.b_resp;
    @(negedge clk_i);
    req.b_ready = 1'b0;
  endtask

  task automatic lite_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    @(negedge clk_i);
    req.ar_valid = 1'b1;
    req.ar_addr  = addr;
    while (!rsp.ar_ready) @(negedge clk_i);
    @(negedge clk_i);
    req.ar_valid = 1'b0;
    req.r_ready  = 1'b1;
    while (!rsp.r_valid) @(negedge clk_i);
    data = rsp.r_data;
    resp = rsp.r_resp;
    @(negedge clk_i);
    req.r_ready = 1'b0;
  endtask

  // a write has just finished, so the flush must be under way
  task automatic wait_flush();
    if (!isolate) begin
      errors++;
      $display("the flush did not start after the register write");
    end
    while (isolate) @(negedge clk_i);
  endtask

  // lowest way first, indices 0 to 15 within each way
  task automatic check_descs(input way_vec_t ways);
    flush_desc_t exp;
    int          k;
    k = 0;
    for (int w = 0; w < `LLC_NUM_WAYS; w++) begin
      if (ways[w]) begin
        for (int i = 0; i < NumIdx; i++) begin
          exp         = '0;
          exp.addr    = 32'(i) << `LLC_BLOCK_OFFSET_W;
          exp.way_ind = way_vec_t'(1) << w;
          exp.flush   = 1'b1;
          checks++;
          if (k < desc_log.size() && desc_log[k] !== exp) begin
            errors++;
            $display("error at %0t: descriptor %0d is addr 0x%08h way 0x%02h, %s 0x%08h 0x%02h",
                     $time, k, desc_log[k].addr, desc_log[k].way_ind, "expected",
                     exp.addr, exp.way_ind);
          end
          k++;
        end
      end
    end
    check_eq("descriptor count", 32'(desc_log.size()), 32'(k));
    desc_log.delete();
  endtask

  task automatic check_bypass(input logic [31:0] aw_a, input logic [31:0] ar_a,
                              input logic exp_aw, input logic exp_ar);
    @(negedge clk_i);
    aw_addr = aw_a;
    ar_addr = ar_a;
    #1;
    check_eq("aw_bypass_o", 32'(aw_bypass), 32'(exp_aw));
    check_eq("ar_bypass_o", 32'(ar_bypass), 32'(exp_ar));
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic test_reset_values();
    logic [31:0] rdata;
    logic [1:0]  resp;
    lite_read(Base + `LLC_REG_FLUSHED, rdata, resp);
    check_eq("FLUSHED", rdata, 32'h0);
    lite_read(Base + `LLC_REG_SPM_CFG, rdata, resp);
    check_eq("SPM_CFG", rdata, 32'h0);
    lite_read(Base + `LLC_REG_SET_ASSO, rdata, resp);
    check_eq("SET_ASSO", rdata, 32'd8);
    lite_read(Base + `LLC_REG_NO_LINES, rdata, resp);
    check_eq("NO_LINES", rdata, 32'd16);
    check_eq("NO_LINES resp", 32'(resp), 32'd0);
    lite_read(Base + 32'h40, rdata, resp);
    check_eq("unmapped read data", rdata, 32'hBADC_0DED);
    check_eq("unmapped read resp", 32'(resp), 32'd2);
  endtask

  task automatic test_spm_flush();
    logic [31:0] rdata;
    logic [1:0]  resp;
    desc_log.delete();
    lite_write(Base + `LLC_REG_SPM_CFG, 32'h05, 4'hF, resp);
    check_eq("SPM_CFG write resp", 32'(resp), 32'd0);
    wait_flush();
    check_descs(8'h05);
    lite_read(Base + `LLC_REG_FLUSHED, rdata, resp);
    check_eq("FLUSHED after spm flush", rdata, 32'h05);
    check_eq("spm_lock_o", 32'(spm_lock), 32'h05);
    check_eq("flushed_o after spm flush", 32'(flushed), 32'h05);
  endtask

  task automatic test_user_flush();
    logic [31:0] rdata;
    logic [1:0]  resp;
    lite_write(Base + `LLC_REG_FLUSH, 32'h02, 4'hF, resp);
    check_eq("FLUSH write resp", 32'(resp), 32'd0);
    wait_flush();
    check_descs(8'h02);
    lite_read(Base + `LLC_REG_FLUSH, rdata, resp);
    check_eq("FLUSH after user flush", rdata, 32'h0);
    lite_read(Base + `LLC_REG_FLUSHED, rdata, resp);
    check_eq("FLUSHED after user flush", rdata, 32'h05);
    check_eq("flushed_o after user flush", 32'(flushed), 32'h05);
  endtask

  task automatic test_write_corners();
    logic [31:0] rdata;
    logic [1:0]  resp;
    lite_write(Base + `LLC_REG_SPM_CFG, 32'hFF, 4'h0, resp);
    check_eq("no strobe write resp", 32'(resp), 32'd0);
    wait_flush();
    check_descs(8'h00);
    lite_read(Base + `LLC_REG_SPM_CFG, rdata, resp);
    check_eq("SPM_CFG after no strobe write", rdata, 32'h05);
    lite_write(Base + `LLC_REG_FLUSHED, 32'hFF, 4'hF, resp);
    check_eq("FLUSHED write resp", 32'(resp), 32'd0);
    wait_flush();
    check_descs(8'h00);
    lite_read(Base + `LLC_REG_FLUSHED, rdata, resp);
    check_eq("FLUSHED after write", rdata, 32'h05);
    lite_write(Base + 32'h40, 32'h1, 4'hF, resp);
    check_eq("unmapped write resp", 32'(resp), 32'd2);
    wait_flush();
    check_descs(8'h00);
  endtask

  task automatic test_bypass();
    logic [31:0] rdata;
    logic [1:0]  resp;
    check_bypass(RamAddr, RamAddr, 1'b0, 1'b0);
    lite_write(Base + `LLC_REG_SPM_CFG, 32'hFF, 4'hF, resp);
    wait_flush();
    // ways 0 and 2 are already flushed
    check_descs(8'hFA);
    lite_read(Base + `LLC_REG_FLUSHED, rdata, resp);
    check_eq("FLUSHED all ways", rdata, 32'hFF);
    check_eq("flushed_o all ways", 32'(flushed), 32'hFF);
    check_bypass(RamAddr, RamAddr, 1'b1, 1'b1);
    check_bypass(32'h8FFF_FFFC, 32'h8FFF_FFFC, 1'b1, 1'b1);
    check_bypass(SpmAddr, SpmAddr, 1'b0, 1'b0);
    check_bypass(32'h4000_0000, 32'h4000_0000, 1'b0, 1'b0);
    check_bypass(32'h9000_0000, 32'h9000_0000, 1'b0, 1'b0);
    // each port decodes its own address
    check_bypass(RamAddr, SpmAddr, 1'b1, 1'b0);
    check_bypass(32'h4000_0000, RamAddr, 1'b0, 1'b1);
  endtask

  initial begin
    lfsr_q     = 32'heff6_9f37;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    req        = '0;
    cache_stat = '0;
    desc_ready = 1'b0;
    aw_addr    = '0;
    ar_addr    = '0;
    ram_rule   = '{start_addr: 32'h8000_0000, end_addr: 32'h9000_0000};
    spm_rule   = '{start_addr: 32'h8800_0000, end_addr: 32'h8801_0000};
    cycles     = 0;
    errors     = 0;
    checks     = 0;
    ncyc       = 0;
    last_due   = 0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_eq("isolate_o after reset", 32'(isolate), 32'h0);
    check_eq("desc_valid_o after reset", 32'(desc_valid), 32'h0);
    check_eq("flushed_o after reset", 32'(flushed), 32'h0);
    test_reset_values();
    test_spm_flush();
    test_user_flush();
    test_write_corners();
    test_bypass();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
llc_cfg_pkg.sv
llc_bypass_dec.sv
llc_cfg_regs.sv
llc_flush_ctrl.sv
llc_cfg_top.sv
tb_llc_cfg.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f sim.f --top-module tb_llc_cfg -Mdir obj_dir
	./obj_dir/Vtb_llc_cfg | tee sim.log
	grep -q "\*\*\* PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
